/* verilog/bus_glue_pkg.sv */
package bus_glue_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////////////////////////

  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int SIZE_W    = 3;
  localparam int TRANS_W   = 2;
  // free-running system timer
  localparam int SYS_CNT_W = 64;

  //////////////////////////////////////////////////////////////////////
  // ahb-lite codes
  //////////////////////////////////////////////////////////////////////

  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

  // hsize, low two bits only
  localparam logic [1:0] SIZE_BYTE = 2'd0;
  localparam logic [1:0] SIZE_HALF = 2'd1;
  localparam logic [1:0] SIZE_WORD = 2'd2;

  // boot flash window on the instruction bus, both ends inclusive
  localparam logic [31:0] FLASH_BASE = 32'h1000_0000;
  localparam logic [31:0] FLASH_END  = 32'h1004_FFFF;

  //////////////////////////////////////////////////////////////////////
  // read lane code
  //////////////////////////////////////////////////////////////////////

  // size and byte offset of one captured read
  typedef struct packed {
    logic [1:0] size;
    logic [1:0] offset;
  } lane_fld_t;

  // raw view is the case index of the lane steering
  typedef union packed {
    logic [3:0] raw;
    lane_fld_t  fld;
  } lane_code_u;

endpackage

/* verilog/ahb_lite_if.sv */
interface ahb_lite_if;

  import bus_glue_pkg::*;

  // address phase, driven by the core side
  logic [ADDR_W-1:0]  haddr;
  logic [TRANS_W-1:0] htrans;
  logic               hwrite;
  logic [SIZE_W-1:0]  hsize;

  // ready as seen by the core
  // low stretches the current data phase
  logic               hready;

  // core side
  modport master (
    output haddr,
    output htrans,
    output hwrite,
    output hsize,
    input  hready
  );

  // glue side only watches the bus
  modport slave (
    input haddr,
    input htrans,
    input hwrite,
    input hsize,
    input hready
  );

endinterface

/* verilog/iahb_slave_select.sv */
module iahb_slave_select (
  input  logic      cpu_clk,
  input  logic      pg_reset_b,
  ahb_lite_if.slave bus,
  input  logic      i_flash_hready,
  input  logic      i_iram_hready,
  output logic      o_flash_hsel,
  output logic      o_iram_hsel,
  output logic      o_flash_busy,
  output logic      o_iram_busy
);

  import bus_glue_pkg::*;

  logic in_flash_win;
  logic trans_act;
  logic flash_stall;
  logic iram_stall;
  logic block;
  logic flash_busy_q;
  logic iram_busy_q;
  logic flash_busy_nxt;
  logic iram_busy_nxt;

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  // flash window, ends included
  assign in_flash_win = (bus.haddr >= FLASH_BASE) && (bus.haddr <= FLASH_END);

  // nonseq or seq
  assign trans_act = bus.htrans[1];

  // busy slave still holding its data phase
  assign flash_stall = flash_busy_q && !i_flash_hready;
  assign iram_stall  = iram_busy_q && !i_iram_hready;
  assign block       = flash_stall || iram_stall;

  // no new select while a data phase is stretched
  // everything outside the window goes to iram
  assign o_flash_hsel = trans_act && !block && in_flash_win;
  assign o_iram_hsel  = trans_act && !block && !in_flash_win;

  //////////////////////////////////////////////////////////////////////
  // busy tracking
  //////////////////////////////////////////////////////////////////////

  // set by select, held until that slave returns ready
  assign flash_busy_nxt = o_flash_hsel || flash_stall;
  assign iram_busy_nxt  = o_iram_hsel || iram_stall;

  always_ff @(posedge cpu_clk or negedge pg_reset_b)
  begin
    if (!pg_reset_b)
    begin
      flash_busy_q <= 1'b0;
      iram_busy_q  <= 1'b0;
    end
    else
    begin
      flash_busy_q <= flash_busy_nxt;
      iram_busy_q  <= iram_busy_nxt;
    end
  end

  assign o_flash_busy = flash_busy_q;
  assign o_iram_busy  = iram_busy_q;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // one address phase routes to one slave only
  a_hsel_excl: assert property (
    @(posedge cpu_clk) disable iff (!pg_reset_b)
    !(o_flash_hsel && o_iram_hsel)
  );

  // handover between slaves never leaves both owning a data phase
  a_busy_excl: assert property (
    @(posedge cpu_clk) disable iff (!pg_reset_b)
    !(flash_busy_q && iram_busy_q)
  );

endmodule

/* verilog/iahb_resp_mux.sv */
module iahb_resp_mux (
  input  logic                            cpu_clk,
  input  logic                            pg_reset_b,
  input  logic                            i_flash_busy,
  input  logic                            i_iram_busy,
  input  logic [bus_glue_pkg::DATA_W-1:0] i_flash_hrdata,
  input  logic [bus_glue_pkg::DATA_W-1:0] i_iram_hrdata,
  input  logic                            i_flash_hready,
  input  logic                            i_iram_hready,
  output logic [bus_glue_pkg::DATA_W-1:0] o_hrdata,
  output logic                            o_hready
);

  import bus_glue_pkg::*;

  // last word handed back to the core
  logic [DATA_W-1:0] hold_q;

  // busy slave drives the response
  always_comb
  begin
    case ({i_flash_busy, i_iram_busy})
      2'b10:
      begin
        o_hrdata = i_flash_hrdata;
        o_hready = i_flash_hready;
      end
      2'b01:
      begin
        o_hrdata = i_iram_hrdata;
        o_hready = i_iram_hready;
      end
      default:
      begin
        // idle, bus free for a new address phase
        o_hrdata = hold_q;
        o_hready = 1'b1;
      end
    endcase
  end

  // capture on the closing edge of each data phase
  always_ff @(posedge cpu_clk or negedge pg_reset_b)
  begin
    if (!pg_reset_b)
      hold_q <= '0;
    else if (i_flash_busy && i_flash_hready)
      hold_q <= i_flash_hrdata;
    else if (i_iram_busy && i_iram_hready)
      hold_q <= i_iram_hrdata;
  end

  // busy comes from the select block, must never overlap
  a_busy_onehot: assert property (
    @(posedge cpu_clk) disable iff (!pg_reset_b)
    $onehot0({i_flash_busy, i_iram_busy})
  );

endmodule

/* verilog/rdata_lane_align.sv */
module rdata_lane_align (
  input  logic                            cpu_clk,
  input  logic                            pg_reset_b,
  ahb_lite_if.slave                       bus,
  input  logic [bus_glue_pkg::DATA_W-1:0] i_hrdata,
  output logic [bus_glue_pkg::DATA_W-1:0] o_hrdata
);

  import bus_glue_pkg::*;

  lane_code_u code_q;
  logic       rd_accept;
  logic       legal_req;

  // read address phase taken on this edge
  assign rd_accept = (bus.htrans == HTRANS_NONSEQ) && !bus.hwrite && bus.hready;

  // size and alignment the lane table can handle
  always_comb
  begin
    case (bus.hsize[1:0])
      SIZE_BYTE: legal_req = 1'b1;
      SIZE_HALF: legal_req = !bus.haddr[0];
      SIZE_WORD: legal_req = (bus.haddr[1:0] == 2'b00);
      default:   legal_req = 1'b0;
    endcase
    legal_req = legal_req && !bus.hsize[2];
  end

  // word at offset 0 out of reset
  always_ff @(posedge cpu_clk or negedge pg_reset_b)
  begin
    if (!pg_reset_b)
    begin
      code_q.fld.size   <= SIZE_WORD;
      code_q.fld.offset <= 2'b00;
    end
    else if (rd_accept)
    begin
      code_q.fld.size   <= bus.hsize[1:0];
      code_q.fld.offset <= bus.haddr[1:0];
    end
  end

  // steer returned word into the lanes the core expects
  always_comb
  begin
    case (code_q.raw)
      {SIZE_BYTE, 2'd0}: o_hrdata = {24'h0, i_hrdata[7:0]};
      {SIZE_BYTE, 2'd1}: o_hrdata = {16'h0, i_hrdata[15:8], 8'h0};
      {SIZE_BYTE, 2'd2}: o_hrdata = {8'h0, i_hrdata[23:16], 16'h0};
      {SIZE_BYTE, 2'd3}: o_hrdata = {i_hrdata[31:24], 24'h0};
      {SIZE_HALF, 2'd0}: o_hrdata = {16'h0, i_hrdata[15:0]};
      {SIZE_HALF, 2'd2}: o_hrdata = {i_hrdata[31:16], 16'h0};
      {SIZE_WORD, 2'd0}: o_hrdata = i_hrdata;
      default:           o_hrdata = '0;
    endcase
  end

  // the master never issues a read the table would zero
  a_legal_code: assert property (
    @(posedge cpu_clk) disable iff (!pg_reset_b)
    rd_accept |-> legal_req
  );

endmodule

/* verilog/sys_timebase.sv */
module sys_timebase (
  input  logic                               cpu_clk,
  input  logic                               pg_reset_b,
  input  logic                               i_hartreset_b,
  output logic [bus_glue_pkg::SYS_CNT_W-1:0] o_sys_cnt,
  output logic                               o_apb_clk_en,
  output logic                               o_cpu_rst_b
);

  import bus_glue_pkg::*;

  logic [SYS_CNT_W-1:0] sys_cnt_q;
  logic                 apb_en_q;

  //////////////////////////////////////////////////////////////////////
  // timebase
  //////////////////////////////////////////////////////////////////////

  // counts cpu_clk cycles since reset release
  always_ff @(posedge cpu_clk or negedge pg_reset_b)
  begin
    if (!pg_reset_b)
      sys_cnt_q <= '0;
    else
      sys_cnt_q <= sys_cnt_q + 1'b1;
  end

  // half-rate enable for the apb side
  always_ff @(posedge cpu_clk or negedge pg_reset_b)
  begin
    if (!pg_reset_b)
      apb_en_q <= 1'b0;
    else
      apb_en_q <= ~apb_en_q;
  end

  assign o_sys_cnt    = sys_cnt_q;
  assign o_apb_clk_en = apb_en_q;

  // core held in reset by power-good or by debug hart reset
  assign o_cpu_rst_b = pg_reset_b & i_hartreset_b;

endmodule

/* verilog/e906_bus_glue.sv */
module e906_bus_glue (
  input  logic                               cpu_clk,
  input  logic                               pg_reset_b,
  // instruction bus request
  input  logic [bus_glue_pkg::ADDR_W-1:0]    i_iahb_haddr,
  input  logic [bus_glue_pkg::TRANS_W-1:0]   i_iahb_htrans,
  input  logic                               i_iahb_hwrite,
  input  logic [bus_glue_pkg::SIZE_W-1:0]    i_iahb_hsize,
  // boot flash and iram responses
  input  logic [bus_glue_pkg::DATA_W-1:0]    i_flash_hrdata,
  input  logic                               i_flash_hready,
  input  logic [bus_glue_pkg::DATA_W-1:0]    i_iram_hrdata,
  input  logic                               i_iram_hready,
  // data bus
  input  logic [bus_glue_pkg::ADDR_W-1:0]    i_dahb_haddr,
  input  logic [bus_glue_pkg::TRANS_W-1:0]   i_dahb_htrans,
  input  logic                               i_dahb_hwrite,
  input  logic [bus_glue_pkg::SIZE_W-1:0]    i_dahb_hsize,
  input  logic [bus_glue_pkg::DATA_W-1:0]    i_dahb_hrdata,
  input  logic                               i_dahb_hready,
  input  logic                               i_hartreset_b,
  output logic                               o_flash_hsel,
  output logic                               o_iram_hsel,
  output logic [bus_glue_pkg::DATA_W-1:0]    o_iahb_hrdata,
  output logic                               o_iahb_hready,
  output logic [bus_glue_pkg::DATA_W-1:0]    o_dahb_hrdata,
  output logic [bus_glue_pkg::SYS_CNT_W-1:0] o_sys_cnt,
  output logic                               o_apb_clk_en,
  output logic                               o_cpu_rst_b
);

  import bus_glue_pkg::*;

  logic              flash_busy;
  logic              iram_busy;
  logic [DATA_W-1:0] iahb_raw_hrdata;
  logic              iahb_hready;

  ahb_lite_if iahb_bus ();
  ahb_lite_if dahb_bus ();

  //////////////////////////////////////////////////////////////////////
  // bus bundles
  //////////////////////////////////////////////////////////////////////

  // core requests straight from the pins
  assign iahb_bus.haddr  = i_iahb_haddr;
  assign iahb_bus.htrans = i_iahb_htrans;
  assign iahb_bus.hwrite = i_iahb_hwrite;
  assign iahb_bus.hsize  = i_iahb_hsize;
  // ibus ready is the muxed slave ready
  assign iahb_bus.hready = iahb_hready;

  assign dahb_bus.haddr  = i_dahb_haddr;
  assign dahb_bus.htrans = i_dahb_htrans;
  assign dahb_bus.hwrite = i_dahb_hwrite;
  assign dahb_bus.hsize  = i_dahb_hsize;
  assign dahb_bus.hready = i_dahb_hready;

  assign o_iahb_hready = iahb_hready;

  //////////////////////////////////////////////////////////////////////
  // instruction bus
  //////////////////////////////////////////////////////////////////////

  iahb_slave_select u_slave_select (
    .cpu_clk        (cpu_clk),
    .pg_reset_b     (pg_reset_b),
    .bus            (iahb_bus),
    .i_flash_hready (i_flash_hready),
    .i_iram_hready  (i_iram_hready),
    .o_flash_hsel   (o_flash_hsel),
    .o_iram_hsel    (o_iram_hsel),
    .o_flash_busy   (flash_busy),
    .o_iram_busy    (iram_busy)
  );

  iahb_resp_mux u_resp_mux (
    .cpu_clk        (cpu_clk),
    .pg_reset_b     (pg_reset_b),
    .i_flash_busy   (flash_busy),
    .i_iram_busy    (iram_busy),
    .i_flash_hrdata (i_flash_hrdata),
    .i_iram_hrdata  (i_iram_hrdata),
    .i_flash_hready (i_flash_hready),
    .i_iram_hready  (i_iram_hready),
    .o_hrdata       (iahb_raw_hrdata),
    .o_hready       (iahb_hready)
  );

  // lanes after the slave mux
  rdata_lane_align u_iahb_align (
    .cpu_clk    (cpu_clk),
    .pg_reset_b (pg_reset_b),
    .bus        (iahb_bus),
    .i_hrdata   (iahb_raw_hrdata),
    .o_hrdata   (o_iahb_hrdata)
  );

  //////////////////////////////////////////////////////////////////////
  // data bus and timebase
  //////////////////////////////////////////////////////////////////////

  rdata_lane_align u_dahb_align (
    .cpu_clk    (cpu_clk),
    .pg_reset_b (pg_reset_b),
    .bus        (dahb_bus),
    .i_hrdata   (i_dahb_hrdata),
    .o_hrdata   (o_dahb_hrdata)
  );

  sys_timebase u_sys_timebase (
    .cpu_clk       (cpu_clk),
    .pg_reset_b    (pg_reset_b),
    .i_hartreset_b (i_hartreset_b),
    .o_sys_cnt     (o_sys_cnt),
    .o_apb_clk_en  (o_apb_clk_en),
    .o_cpu_rst_b   (o_cpu_rst_b)
  );

endmodule

/* verif/tb_e906_bus_glue.sv */
module tb_e906_bus_glue;

  timeunit 1ns;
  timeprecision 1ps;

  import bus_glue_pkg::*;

  localparam int          MAX_LINES = 64;
  localparam logic [1:0]  HT_IDLE   = 2'b00;
  // boot flash window from the memory map, both ends inside
  localparam logic [31:0] WIN_LO    = 32'h1000_0000;
  localparam logic [31:0] WIN_HI    = 32'h1004_FFFF;

  logic                 cpu_clk;
  logic                 pg_reset_b;
  logic [ADDR_W-1:0]    i_iahb_haddr;
  logic [TRANS_W-1:0]   i_iahb_htrans;
  logic                 i_iahb_hwrite;
  logic [SIZE_W-1:0]    i_iahb_hsize;
  logic [DATA_W-1:0]    i_flash_hrdata;
  logic                 i_flash_hready;
  logic [DATA_W-1:0]    i_iram_hrdata;
  logic                 i_iram_hready;
  logic [ADDR_W-1:0]    i_dahb_haddr;
  logic [TRANS_W-1:0]   i_dahb_htrans;
  logic                 i_dahb_hwrite;
  logic [SIZE_W-1:0]    i_dahb_hsize;
  logic [DATA_W-1:0]    i_dahb_hrdata;
  logic                 i_dahb_hready;
  logic                 i_hartreset_b;
  logic                 o_flash_hsel;
  logic                 o_iram_hsel;
  logic [DATA_W-1:0]    o_iahb_hrdata;
  logic                 o_iahb_hready;
  logic [DATA_W-1:0]    o_dahb_hrdata;
  logic [SYS_CNT_W-1:0] o_sys_cnt;
  logic                 o_apb_clk_en;
  logic                 o_cpu_rst_b;

  // one golden line per entry
  byte         bus_q  [MAX_LINES];
  logic [31:0] addr_q [MAX_LINES];
  logic [2:0]  size_q [MAX_LINES];
  int          wait_q [MAX_LINES];
  logic [31:0] data_q [MAX_LINES];
  logic [31:0] exp_q  [MAX_LINES];
  int          line_cnt;
  bit          load_done;
  logic [63:0] cyc_cnt;

  e906_bus_glue DUT (.*);

  //////////////////////////////////////////////////////////////////////
  // clock, cycle count, enable monitor
  //////////////////////////////////////////////////////////////////////

  always #10 cpu_clk = ~cpu_clk;

  // cycles since reset release
  always @(posedge cpu_clk)
  begin
    if (!pg_reset_b)
      cyc_cnt <= '0;
    else
      cyc_cnt <= cyc_cnt + 64'd1;
  end

  // half-rate enable, low right after reset
  always @(negedge cpu_clk)
  begin
    if (pg_reset_b)
      check_eq("o_apb_clk_en", {63'd0, cyc_cnt[0]}, {63'd0, o_apb_clk_en});
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_eq(
    input string       name,
    input logic [63:0] exp_v,
    input logic [63:0] act_v
  );
    assert (act_v === exp_v)
    else
      stop_run($sformatf("FAILED at %0d ns: %s expected %h got %h",
                         $time, name, exp_v, act_v));
  endtask

  task automatic check_sel(input logic to_flash, input logic active);
    check_eq("o_flash_hsel", {63'd0, active && to_flash}, {63'd0, o_flash_hsel});
    check_eq("o_iram_hsel", {63'd0, active && !to_flash}, {63'd0, o_iram_hsel});
  endtask

  // closing cycle of a data phase
  task automatic check_phase_end(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    check_eq(name, {32'd0, exp_v}, {32'd0, act_v});
    check_eq("o_sys_cnt", cyc_cnt, o_sys_cnt);
  endtask

  task automatic load_golden();
    int          fd;
    int          n;
    string       line;
    byte         bus_c;
    logic [31:0] addr;
    int          sz;
    int          ws;
    logic [31:0] dat;
    logic [31:0] ex;
    fd = $fopen("verif/bus_glue_golden.txt", "r");
    if (fd == 0)
      stop_run("golden file verif/bus_glue_golden.txt could not be opened");
    line_cnt = 0;
    while ($fgets(line, fd) != 0)
    begin
      // column notes and blank lines
      if (line.getc(0) != "#" && line.getc(0) != "\n")
      begin
        n = $sscanf(line, "%c %h %d %d %h %h", bus_c, addr, sz, ws, dat, ex);
        if (n != 6 || line_cnt == MAX_LINES)
          stop_run($sformatf("golden entry %0d could not be read", line_cnt + 1));
        bus_q[line_cnt]  = bus_c;
        addr_q[line_cnt] = addr;
        size_q[line_cnt] = sz[2:0];
        wait_q[line_cnt] = ws;
        data_q[line_cnt] = dat;
        exp_q[line_cnt]  = ex;
        line_cnt++;
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // slave model and transfers
  //////////////////////////////////////////////////////////////////////

  // the other slave stays ready, inverted data shows a wrong mux pick
  task automatic drive_slave(input logic to_flash, input logic rdy, input logic [31:0] dat);
    i_flash_hready = to_flash ? rdy : 1'b1;
    i_iram_hready  = to_flash ? 1'b1 : rdy;
    i_flash_hrdata = to_flash ? dat : ~dat;
    i_iram_hrdata  = to_flash ? ~dat : dat;
  endtask

  task automatic run_ibus(input int idx);
    logic to_flash;
    int   w;
    to_flash = (addr_q[idx] >= WIN_LO) && (addr_q[idx] <= WIN_HI);
    // address phase on an idle bus
    i_iahb_haddr  = addr_q[idx];
    i_iahb_htrans = HTRANS_NONSEQ;
    i_iahb_hsize  = size_q[idx];
    drive_slave(to_flash, 1'b1, 32'h0);
    #1;
    check_sel(to_flash, 1'b1);
    check_eq("o_iahb_hready", 64'd1, {63'd0, o_iahb_hready});
    @(negedge cpu_clk);
    // with wait states the request stays up as a retry
    if (wait_q[idx] == 0)
      i_iahb_htrans = HT_IDLE;
    for (w = 0; w < wait_q[idx]; w++)
    begin
      drive_slave(to_flash, 1'b0, data_q[idx]);
      #1;
      // back-pressure
      check_sel(to_flash, 1'b0);
      check_eq("o_iahb_hready", 64'd0, {63'd0, o_iahb_hready});
      @(negedge cpu_clk);
    end
    drive_slave(to_flash, 1'b1, data_q[idx]);
    #1;
    check_eq("o_iahb_hready", 64'd1, {63'd0, o_iahb_hready});
    check_phase_end("o_iahb_hrdata", exp_q[idx], o_iahb_hrdata);
    if (wait_q[idx] > 0)
    begin
      // ready back, retry selected and answered with the same word
      check_sel(to_flash, 1'b1);
      @(negedge cpu_clk);
      i_iahb_htrans = HT_IDLE;
      #1;
      check_phase_end("o_iahb_hrdata", exp_q[idx], o_iahb_hrdata);
    end
    @(negedge cpu_clk);
    i_iahb_htrans = HT_IDLE;
    // both slaves idle, live data changed, held word still returned
    drive_slave(to_flash, 1'b1, ~data_q[idx]);
    #1;
    check_eq("o_iahb_hrdata", {32'd0, exp_q[idx]}, {32'd0, o_iahb_hrdata});
  endtask

  task automatic run_dbus(input int idx);
    int w;
    i_dahb_haddr  = addr_q[idx];
    i_dahb_htrans = HTRANS_NONSEQ;
    i_dahb_hsize  = size_q[idx];
    i_dahb_hready = 1'b1;
    @(negedge cpu_clk);
    i_dahb_htrans = HT_IDLE;
    // stretched data phase, raw word not valid yet
    for (w = 0; w < wait_q[idx]; w++)
    begin
      i_dahb_hready = 1'b0;
      i_dahb_hrdata = ~data_q[idx];
      @(negedge cpu_clk);
    end
    i_dahb_hready = 1'b1;
    i_dahb_hrdata = data_q[idx];
    #1;
    check_phase_end("o_dahb_hrdata", exp_q[idx], o_dahb_hrdata);
    @(negedge cpu_clk);
  endtask

  task automatic pulse_hartreset();
    i_hartreset_b = 1'b0;
    #1;
    check_eq("o_cpu_rst_b", 64'd0, {63'd0, o_cpu_rst_b});
    @(negedge cpu_clk);
    i_hartreset_b = 1'b1;
    #1;
    check_eq("o_cpu_rst_b", 64'd1, {63'd0, o_cpu_rst_b});
    @(negedge cpu_clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int idx;
    cpu_clk       = 1'b0;
    pg_reset_b    = 1'b0;
    i_hartreset_b = 1'b1;
    i_iahb_haddr  = '0;
    i_iahb_htrans = HT_IDLE;
    i_iahb_hwrite = 1'b0;
    i_iahb_hsize  = '0;
    i_dahb_haddr  = '0;
    i_dahb_htrans = HT_IDLE;
    i_dahb_hwrite = 1'b0;
    i_dahb_hsize  = '0;
    i_dahb_hrdata = '0;
    i_dahb_hready = 1'b1;
    drive_slave(1'b1, 1'b1, 32'h0);
    load_golden();
    load_done = 1'b1;
    // four cycles in reset
    repeat (4) @(negedge cpu_clk);
    check_sel(1'b1, 1'b0);
    check_eq("o_iahb_hready", 64'd1, {63'd0, o_iahb_hready});
    check_eq("o_sys_cnt", 64'd0, o_sys_cnt);
    check_eq("o_cpu_rst_b", 64'd0, {63'd0, o_cpu_rst_b});
    pg_reset_b = 1'b1;
    #1;
    check_eq("o_cpu_rst_b", 64'd1, {63'd0, o_cpu_rst_b});
    @(negedge cpu_clk);
    for (idx = 0; idx < line_cnt; idx++)
    begin
      // one hart reset pulse halfway through
      if (idx == line_cnt / 2)
        pulse_hartreset();
      if (bus_q[idx] == "i")
        run_ibus(idx);
      else
        run_dbus(idx);
    end
    $display("TB PASSED");
    $finish;
  end

  // 40 cycles per golden entry plus reset
  initial
  begin
    wait (load_done);
    repeat (line_cnt * 40 + 8) @(posedge cpu_clk);
    stop_run($sformatf("watchdog expired, %0d transfers did not finish in time", line_cnt));
  end

endmodule

/* e906_bus_glue.f */
verilog/bus_glue_pkg.sv
verilog/ahb_lite_if.sv
verilog/iahb_slave_select.sv
verilog/iahb_resp_mux.sv
verilog/rdata_lane_align.sv
verilog/sys_timebase.sv
verilog/e906_bus_glue.sv
verif/tb_e906_bus_glue.sv

/* Makefile */
# Verilator build and run for the bus glue testbench

TOP := tb_e906_bus_glue

.PHONY: all lint clean

# the run passes only when the testbench prints its pass line
all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

obj_dir/V$(TOP): e906_bus_glue.f $(shell cat e906_bus_glue.f)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f e906_bus_glue.f

lint:
	verilator --lint-only -Wall --timing --top-module e906_bus_glue -f e906_bus_glue.f

clean:
	rm -rf obj_dir

/* verif/bus_glue_golden.txt */
# bus(i/d) address(hex) hsize(0 byte,1 half,2 word) wait_states slave_data(hex) expected(hex)
# expected is the slave word steered into the lanes of the read
i 10000000 2 0 13579bdf 13579bdf
i 1004fffc 2 1 2468ace0 2468ace0
i 1004ffff 0 2 a1b2c3d4 a1000000
i 10050000 2 1 0badf00d 0badf00d
i 0ffffffc 2 0 cafebabe cafebabe
i 10000002 1 3 89abcdef 89ab0000
i 20000000 1 1 fedcba98 0000ba98
i 20000001 0 0 11223344 00003300
i 10040002 0 2 55667788 00660000
i 00000000 0 1 deadbeef 000000ef
d 40000000 2 0 01234567 01234567
d 40000001 0 1 76543210 00003200
d 40000002 0 0 f00dcafe 000d0000
d 40000003 0 2 8badf00d 8b000000
d 40000000 0 0 abcdef12 00000012
d 40000004 1 1 c0ffee11 0000ee11
d 40000006 1 3 5a5aa5a5 5a5a0000
d 40000008 2 2 9e3779b9 9e3779b9
i 10000001 0 1 aabbccdd 0000cc00
i 1004fffe 1 0 7fff8001 7fff0000
i 10050002 1 2 33445566 33440000
i 30000000 2 4 ffffffff ffffffff
i 0fffffff 0 0 4455aa66 44000000
